/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f files.f --top-module tb_upsample2x

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module tb_upsample2x -o tb_upsample2x
	./obj_dir/tb_upsample2x > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* audio_fmt_pkg.sv */
package audio_fmt_pkg;

    // audio sample width, two's complement
    localparam int SAMPLE_W = 24;

    // filter coefficient width, Q1.15
    localparam int COEF_W = 16;

    // product is shifted right by this to return to sample scale
    localparam int COEF_FRAC = 15;

endpackage

/* coef_rom.hex */
// one signed 16-bit coefficient per line, phase 0 taps 0..31 then phase 1 taps 0..31
000c
ffdd
003d
ff9e
0096
ff23
013e
fe3f
0274
fc90
04e2
f8cd
0b7e
ea48
42b8
747c
1c48
ef2a
096a
f9e8
0438
fcfe
0226
fe7a
010e
ff4a
0076
ffb8
0029
ffeb
0009
fffd
fffd
0009
ffeb
0029
ffb8
0076
ff4a
010e
fe7a
0226
fcfe
0438
f9e8
096a
ef2a
1c48
747c
42b8
ea48
0b7e
f8cd
04e2
fc90
0274
fe3f
013e
ff23
0096
ff9e
003d
ffdd
000c

/* coef_rom.sv */
`timescale 1ns/1ps

module coef_rom (
    input  logic [resamp_cfg_pkg::BANK_WIDTH-1:0]    addr_i,
    output logic signed [audio_fmt_pkg::COEF_W-1:0] data_o
);
    import resamp_cfg_pkg::*;
    import audio_fmt_pkg::*;

    // entry phase*32+tap, phase 0 first
    logic signed [COEF_W-1:0] rom [2**BANK_WIDTH];

    initial begin
        $readmemh("coef_rom.hex", rom);
    end

    // asynchronous read, shared by both channels through an OR of addresses
    assign data_o = rom[addr_i];

endmodule

/* files.f */
resamp_cfg_pkg.sv
audio_fmt_pkg.sv
coef_rom.sv
ring_buffer.sv
pipe_mult.sv
resampler_1ch.sv
upsample2x.sv
upsample2x_asserts.sv
tb_upsample2x.sv

/* pipe_mult.sv */
`timescale 1ns/1ps

module pipe_mult (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic signed [audio_fmt_pkg::SAMPLE_W-1:0] mpcand_i,
    input  logic signed [audio_fmt_pkg::COEF_W-1:0]   mplier_i,
    output logic signed [audio_fmt_pkg::SAMPLE_W-1:0] mprod_o
);
    import resamp_cfg_pkg::*;
    import audio_fmt_pkg::*;

    // full precision products in flight
    logic signed [SAMPLE_W+COEF_W-1:0] prod_q [MULT_LATENCY];
    logic signed [SAMPLE_W+COEF_W-1:0] prod_scaled;

    // free-running, a new operand pair may enter every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MULT_LATENCY; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            prod_q[0] <= mpcand_i * mplier_i;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    // back to sample scale, upper bits dropped
    assign prod_scaled = prod_q[MULT_LATENCY-1] >>> COEF_FRAC;
    assign mprod_o     = prod_scaled[SAMPLE_W-1:0];

endmodule

/* resamp_cfg_pkg.sv */
package resamp_cfg_pkg;

    // polyphase filter geometry
    localparam int FIRDEPTH      = 32;
    localparam int FIRDEPTH_LOG2 = 5;
    localparam int NUM_FIR       = 2;
    localparam int NUM_FIR_LOG2  = 1;

    // input samples consumed per output, in units of 1/NUM_FIR
    localparam int DECIM = 1;

    // shared multiplier register stages
    localparam int MULT_LATENCY = 4;

    // address, operand load, multiply and accumulate
    localparam int PIPELINEDEPTH = MULT_LATENCY + 3;

    // coefficient ROM address is phase concatenated with tap
    localparam int BANK_WIDTH = NUM_FIR_LOG2 + FIRDEPTH_LOG2;

    // per-channel sample ring, larger than one FIR span for input jitter
    localparam int RING_LEN      = 64;
    localparam int RING_LEN_LOG2 = 6;

endpackage

/* resampler_1ch.sv */
`timescale 1ns/1ps

module resampler_1ch (
    input  logic                                      clk,
    input  logic                                      rst,
    // shared ROM and multiplier
    input  logic                                      shres_ready_i,
    output logic [resamp_cfg_pkg::BANK_WIDTH-1:0]     bank_addr_o,
    input  logic signed [audio_fmt_pkg::COEF_W-1:0]   bank_data_i,
    output logic signed [audio_fmt_pkg::SAMPLE_W-1:0] mpcand_o,
    output logic signed [audio_fmt_pkg::COEF_W-1:0]   mplier_o,
    input  logic signed [audio_fmt_pkg::SAMPLE_W-1:0] mprod_i,
    // own ring buffer
    output logic                                      ring_pop_o,
    output logic [resamp_cfg_pkg::FIRDEPTH_LOG2-1:0]  offset_o,
    input  logic [audio_fmt_pkg::SAMPLE_W-1:0]        ring_data_i,
    // output request and result
    input  logic                                      req_i,
    output logic [audio_fmt_pkg::SAMPLE_W-1:0]        data_o,
    output logic                                      ack_o
);
    import resamp_cfg_pkg::*;
    import audio_fmt_pkg::*;

    localparam logic [2:0] ST_IDLE         = 3'd0;
    localparam logic [2:0] ST_RESULT       = 3'd1;
    localparam logic [2:0] ST_CALC_PENDING = 3'd2;
    localparam logic [2:0] ST_CALC         = 3'd3;
    localparam logic [2:0] ST_NEXT_PHASE   = 3'd4;

    logic [2:0]                 state_q;
    // one extra bit, the count runs past FIRDEPTH to drain the pipeline
    logic [FIRDEPTH_LOG2:0]     depth_q;
    logic [NUM_FIR_LOG2-1:0]    phase_q;
    logic [NUM_FIR_LOG2:0]      pop_acc_q;
    logic [NUM_FIR_LOG2:0]      pop_acc_next;
    logic signed [SAMPLE_W-1:0] sample_q;
    logic signed [COEF_W-1:0]   coef_q;
    logic signed [SAMPLE_W-1:0] acc_q;
    logic                       tap_issue;
    logic                       tap_sum;

    // address stage covers taps 0..FIRDEPTH-1
    assign tap_issue = (state_q == ST_CALC) &&
                       (depth_q < (FIRDEPTH_LOG2+1)'(FIRDEPTH));

    // product of address d shows up at mprod_i in cycle d+MULT_LATENCY+1
    assign tap_sum = (state_q == ST_CALC) &&
                     (depth_q >= (FIRDEPTH_LOG2+1)'(PIPELINEDEPTH-2)) &&
                     (depth_q < (FIRDEPTH_LOG2+1)'(FIRDEPTH+PIPELINEDEPTH-2));

    // zero when idle so the top can OR the channels together
    assign bank_addr_o = tap_issue ? {phase_q, depth_q[FIRDEPTH_LOG2-1:0]} : '0;
    assign offset_o    = depth_q[FIRDEPTH_LOG2-1:0];
    assign mpcand_o    = sample_q;
    assign mplier_o    = coef_q;

    // decimation accumulator, pop once it reaches NUM_FIR
    assign pop_acc_next = pop_acc_q + (NUM_FIR_LOG2+1)'(DECIM);
    assign ring_pop_o   = (state_q == ST_NEXT_PHASE) &&
                          (pop_acc_next >= (NUM_FIR_LOG2+1)'(NUM_FIR));

    // ack carries the previous request's result
    assign ack_o  = (state_q == ST_RESULT);
    assign data_o = ack_o ? acc_q : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            depth_q   <= '0;
            phase_q   <= '0;
            pop_acc_q <= '0;
            sample_q  <= '0;
            coef_q    <= '0;
            acc_q     <= '0;
        end else begin
            // operand stage, zero outside of tap loads
            sample_q <= '0;
            coef_q   <= '0;
            if (tap_issue) begin
                sample_q <= ring_data_i;
                coef_q   <= bank_data_i;
            end

            if (tap_sum) begin
                acc_q <= acc_q + mprod_i;
            end

            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= ST_RESULT;
                    end
                end
                ST_RESULT: begin
                    acc_q <= '0;
                    if (shres_ready_i) begin
                        state_q <= ST_CALC;
                    end else begin
                        state_q <= ST_CALC_PENDING;
                    end
                end
                ST_CALC_PENDING: begin
                    if (shres_ready_i) begin
                        state_q <= ST_CALC;
                    end
                end
                ST_CALC: begin
                    // keeps issuing even if ready drops
                    if (depth_q == (FIRDEPTH_LOG2+1)'(FIRDEPTH+PIPELINEDEPTH-1)) begin
                        depth_q <= '0;
                        state_q <= ST_NEXT_PHASE;
                    end else begin
                        depth_q <= depth_q + 1'b1;
                    end
                end
                ST_NEXT_PHASE: begin
                    if (phase_q == NUM_FIR_LOG2'(NUM_FIR-1)) begin
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                    if (ring_pop_o) begin
                        pop_acc_q <= pop_acc_next - (NUM_FIR_LOG2+1)'(NUM_FIR);
                    end else begin
                        pop_acc_q <= pop_acc_next;
                    end
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* ring_buffer.sv */
`timescale 1ns/1ps

module ring_buffer #(
    parameter int LEN      = resamp_cfg_pkg::RING_LEN,
    parameter int LEN_LOG2 = resamp_cfg_pkg::RING_LEN_LOG2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [audio_fmt_pkg::SAMPLE_W-1:0] data_i,
    input  logic                               we_i,
    input  logic                               pop_i,
    input  logic [LEN_LOG2-1:0]                offset_i,
    output logic [audio_fmt_pkg::SAMPLE_W-1:0] data_o
);
    import audio_fmt_pkg::*;

    logic [SAMPLE_W-1:0] mem [LEN];
    logic [LEN_LOG2-1:0] wr_ptr_q;
    logic [LEN_LOG2-1:0] rd_ptr_q;
    logic [LEN_LOG2-1:0] rd_addr;

    // pointers wrap naturally, LEN is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (we_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // offset 0 is the oldest unpopped sample
    assign rd_addr = rd_ptr_q + offset_i;
    assign data_o  = mem[rd_addr];

endmodule

/* tb_upsample2x.sv */
`timescale 1ns/1ps

module tb_upsample2x;
    import resamp_cfg_pkg::*;
    import audio_fmt_pkg::*;

    localparam int ACK_TIMEOUT  = 20;
    localparam int IDLE_CYCLES  = 45;
    localparam int IDLE_TIMEOUT = 400;

    logic                clk;
    logic                rst;
    logic                grant_i;
    logic [1:0]          ring_we_i;
    logic [SAMPLE_W-1:0] sample_i;
    logic [1:0]          req_i;
    logic [1:0]          ring_pop_o;
    logic [SAMPLE_W-1:0] data_o;
    logic [1:0]          ack_o;

    // reference model state
    logic [COEF_W-1:0]   coef_mem [2**BANK_WIDTH];
    logic [SAMPLE_W-1:0] model_q0 [$];
    logic [SAMPLE_W-1:0] model_q1 [$];
    logic [SAMPLE_W-1:0] pending [2];
    logic                model_phase [2];
    int                  exp_pops [2];
    int                  pop_count [2];
    int                  seed = 34;
    int                  errors = 0;
    int                  checks = 0;

    upsample2x upsample2x_inst (
        .clk        (clk),
        .rst        (rst),
        .grant_i    (grant_i),
        .ring_we_i  (ring_we_i),
        .sample_i   (sample_i),
        .req_i      (req_i),
        .ring_pop_o (ring_pop_o),
        .data_o     (data_o),
        .ack_o      (ack_o)
    );

    bind upsample2x upsample2x_asserts upsample2x_asserts_inst (
        .clk      (clk),
        .rst      (rst),
        .grant_i  (grant_i),
        .req_i    (req_i),
        .ack_i    (ack_o),
        .mpcand_i (mpcand),
        .mplier_i (mplier),
        .state0_i (g_ch[0].resampler_1ch_inst.state_q),
        .state1_i (g_ch[1].resampler_1ch_inst.state_q)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // pops seen on each channel
    always @(negedge clk) begin
        if (!rst) begin
            if (ring_pop_o[0]) begin
                pop_count[0] = pop_count[0] + 1;
            end
            if (ring_pop_o[1]) begin
                pop_count[1] = pop_count[1] + 1;
            end
        end
    end

    function automatic logic [SAMPLE_W-1:0] random_sample();
        int r;
        r = $random(seed);
        return r[SAMPLE_W-1:0];
    endfunction

    // one FIR phase over the oldest FIRDEPTH samples with a wrapping sum
    function automatic logic [SAMPLE_W-1:0] fir_phase(input logic ch, input logic ph);
        logic [SAMPLE_W-1:0]        acc;
        logic signed [SAMPLE_W-1:0] smp;
        logic signed [COEF_W-1:0]   cf;
        logic [BANK_WIDTH-1:0]      idx;
        longint                     prod;
        acc = '0;
        for (int k = 0; k < FIRDEPTH; k++) begin
            smp  = ch ? model_q1[k] : model_q0[k];
            idx  = {ph, k[FIRDEPTH_LOG2-1:0]};
            cf   = coef_mem[idx];
            prod = longint'(smp) * longint'(cf);
            prod = prod >>> COEF_FRAC;
            acc  = acc + prod[SAMPLE_W-1:0];
        end
        return acc;
    endfunction

    task automatic push_sample(input logic ch, input logic [SAMPLE_W-1:0] val);
        @(posedge clk);
        ring_we_i <= ch ? 2'b10 : 2'b01;
        sample_i  <= val;
        @(posedge clk);
        ring_we_i <= 2'b00;
        if (ch) begin
            model_q1.push_back(val);
        end else begin
            model_q0.push_back(val);
        end
    endtask

    // request one output and check the ack before advancing the model
    task automatic send_request(input logic ch);
        logic [1:0]          mask;
        logic [SAMPLE_W-1:0] expected;
        int                  cycles;
        mask     = ch ? 2'b10 : 2'b01;
        expected = pending[ch];
        @(posedge clk);
        req_i <= mask;
        @(posedge clk);
        req_i <= 2'b00;
        cycles = 0;
        @(negedge clk);
        while ((ack_o & mask) == 2'b00 && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if ((ack_o & mask) == 2'b00) begin
            errors++;
            $display("no ack from channel %0d within %0d cycles", ch, ACK_TIMEOUT);
        end else begin
            if (cycles != 0) begin
                errors++;
                $display("ack from channel %0d came %0d cycles late", ch, cycles);
            end
            if (ack_o !== mask) begin
                errors++;
                $display("mismatch ack_o: got %h expected %h", ack_o, mask);
            end
            if (data_o !== expected) begin
                errors++;
                $display("mismatch data_o: got %h expected %h", data_o, expected);
            end
        end
        pending[ch] = fir_phase(ch, model_phase[ch]);
        // a pop follows every phase 1 computation
        if (model_phase[ch]) begin
            if (ch) begin
                void'(model_q1.pop_front());
            end else begin
                void'(model_q0.pop_front());
            end
            exp_pops[ch]++;
        end
        model_phase[ch] = !model_phase[ch];
    endtask

    // idle once grant has been high for IDLE_CYCLES since the ack
    task automatic finish_request(input logic ch);
        int high_cycles;
        int cycles;
        high_cycles = 0;
        cycles      = 0;
        while (high_cycles < IDLE_CYCLES && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            // no request is outstanding so both channels drive zeros
            checks++;
            if (ack_o !== 2'b00 || data_o !== '0) begin
                errors++;
                $display("mismatch ack_o/data_o without request: got %h %h expected %h %h",
                         ack_o, data_o, 2'b00, 24'h000000);
            end
            if (grant_i) begin
                high_cycles++;
            end
            cycles++;
        end
        if (high_cycles < IDLE_CYCLES) begin
            errors++;
            $display("channel %0d not idle within %0d cycles", ch, IDLE_TIMEOUT);
        end
        checks++;
        if (pop_count[0] != exp_pops[0] || pop_count[1] != exp_pops[1]) begin
            errors++;
            $display("mismatch ring_pop_o count: got %h %h expected %h %h",
                     pop_count[1], pop_count[0], exp_pops[1], exp_pops[0]);
        end
    endtask

    task automatic outputs_after_reset();
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (ack_o !== 2'b00 || ring_pop_o !== 2'b00 || data_o !== '0) begin
                errors++;
                $display("mismatch ack_o/ring_pop_o/data_o after reset: got %h %h %h",
                         ack_o, ring_pop_o, data_o);
            end
        end
    endtask

    // impulse at offset 31 on ch0 and random history on ch1
    task automatic preload_rings();
        for (int i = 0; i < RING_LEN; i++) begin
            push_sample(1'b0, (i == FIRDEPTH - 1) ? 24'h008000 : 24'h000000);
        end
        for (int i = 0; i < 40; i++) begin
            push_sample(1'b1, random_sample());
        end
    endtask

    task automatic first_acks_zero();
        send_request(1'b0);
        finish_request(1'b0);
        send_request(1'b1);
        finish_request(1'b1);
    endtask

    // impulse walks down one tap per pop and shows both phases
    task automatic impulse_response();
        repeat (8) begin
            send_request(1'b0);
            finish_request(1'b0);
        end
    endtask

    task automatic random_input();
        repeat (8) begin
            push_sample(1'b1, random_sample());
            send_request(1'b1);
            finish_request(1'b1);
        end
    endtask

    task automatic stereo_alternation();
        repeat (6) begin
            if (model_q0.size() < RING_LEN) begin
                push_sample(1'b0, random_sample());
            end
            if (model_q1.size() < RING_LEN) begin
                push_sample(1'b1, random_sample());
            end
            send_request(1'b0);
            finish_request(1'b0);
            send_request(1'b1);
            finish_request(1'b1);
        end
    endtask

    // held request on a phase 1 so a pop would be due
    task automatic grant_hold();
        if (!model_phase[0]) begin
            send_request(1'b0);
            finish_request(1'b0);
        end
        @(posedge clk);
        grant_i <= 1'b0;
        send_request(1'b0);
        repeat (60) begin
            @(negedge clk);
            checks++;
            if (ring_pop_o !== 2'b00) begin
                errors++;
                $display("mismatch ring_pop_o: got %h expected %h", ring_pop_o, 2'b00);
            end
        end
        @(posedge clk);
        grant_i <= 1'b1;
        finish_request(1'b0);
        send_request(1'b0);
        finish_request(1'b0);
    endtask

    initial begin
        rst            = 1'b1;
        grant_i        = 1'b1;
        ring_we_i      = 2'b00;
        sample_i       = '0;
        req_i          = 2'b00;
        pending[0]     = '0;
        pending[1]     = '0;
        model_phase[0] = 1'b0;
        model_phase[1] = 1'b0;
        exp_pops[0]    = 0;
        exp_pops[1]    = 0;
        pop_count[0]   = 0;
        pop_count[1]   = 0;
        $readmemh("coef_rom.hex", coef_mem);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        outputs_after_reset();
        preload_rings();
        first_acks_zero();
        impulse_response();
        random_input();
        stereo_alternation();
        grant_hold();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* upsample2x.sv */
`timescale 1ns/1ps

module upsample2x (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               grant_i,
    input  logic [1:0]                         ring_we_i,
    input  logic [audio_fmt_pkg::SAMPLE_W-1:0] sample_i,
    input  logic [1:0]                         req_i,
    output logic [1:0]                         ring_pop_o,
    output logic [audio_fmt_pkg::SAMPLE_W-1:0] data_o,
    output logic [1:0]                         ack_o
);
    import resamp_cfg_pkg::*;
    import audio_fmt_pkg::*;

    logic                       last_req_q;
    logic [1:0]                 shres_ready;
    logic [BANK_WIDTH-1:0]      ch_bank_addr [2];
    logic [BANK_WIDTH-1:0]      bank_addr;
    logic signed [COEF_W-1:0]   bank_data;
    logic signed [SAMPLE_W-1:0] ch_mpcand [2];
    logic signed [COEF_W-1:0]   ch_mplier [2];
    logic signed [SAMPLE_W-1:0] mpcand;
    logic signed [COEF_W-1:0]   mplier;
    logic signed [SAMPLE_W-1:0] mprod;
    logic [FIRDEPTH_LOG2-1:0]   ch_offset [2];
    logic [SAMPLE_W-1:0]        ch_ring_data [2];
    logic [SAMPLE_W-1:0]        ch_data [2];

    // most recent requester owns ROM and multiplier
    always_ff @(posedge clk) begin
        if (rst) begin
            last_req_q <= 1'b0;
        end else if (req_i[0]) begin
            last_req_q <= 1'b0;
        end else if (req_i[1]) begin
            last_req_q <= 1'b1;
        end
    end

    // external grant holds both channels off
    assign shres_ready[0] = grant_i && !last_req_q;
    assign shres_ready[1] = grant_i && last_req_q;

    // inactive channels drive zeros
    assign bank_addr = ch_bank_addr[0] | ch_bank_addr[1];
    assign mpcand    = ch_mpcand[0] | ch_mpcand[1];
    assign mplier    = ch_mplier[0] | ch_mplier[1];
    assign data_o    = ch_data[0] | ch_data[1];

    coef_rom coef_rom_inst (
        .addr_i (bank_addr),
        .data_o (bank_data)
    );

    pipe_mult pipe_mult_inst (
        .clk      (clk),
        .rst      (rst),
        .mpcand_i (mpcand),
        .mplier_i (mplier),
        .mprod_o  (mprod)
    );

    for (genvar ch = 0; ch < 2; ch++) begin : g_ch
        ring_buffer #(
            .LEN      (RING_LEN),
            .LEN_LOG2 (RING_LEN_LOG2)
        ) ring_buffer_inst (
            .clk      (clk),
            .rst      (rst),
            .data_i   (sample_i),
            .we_i     (ring_we_i[ch]),
            .pop_i    (ring_pop_o[ch]),
            .offset_i ({{(RING_LEN_LOG2-FIRDEPTH_LOG2){1'b0}}, ch_offset[ch]}),
            .data_o   (ch_ring_data[ch])
        );

        resampler_1ch resampler_1ch_inst (
            .clk           (clk),
            .rst           (rst),
            .shres_ready_i (shres_ready[ch]),
            .bank_addr_o   (ch_bank_addr[ch]),
            .bank_data_i   (bank_data),
            .mpcand_o      (ch_mpcand[ch]),
            .mplier_o      (ch_mplier[ch]),
            .mprod_i       (mprod),
            .ring_pop_o    (ring_pop_o[ch]),
            .offset_o      (ch_offset[ch]),
            .ring_data_i   (ch_ring_data[ch]),
            .req_i         (req_i[ch]),
            .data_o        (ch_data[ch]),
            .ack_o         (ack_o[ch])
        );
    end

endmodule

/* upsample2x_asserts.sv */
`timescale 1ns/1ps

module upsample2x_asserts (
    input logic                               clk,
    input logic                               rst,
    input logic                               grant_i,
    input logic [1:0]                         req_i,
    input logic [1:0]                         ack_i,
    input logic [audio_fmt_pkg::SAMPLE_W-1:0] mpcand_i,
    input logic [audio_fmt_pkg::COEF_W-1:0]   mplier_i,
    input logic [2:0]                         state0_i,
    input logic [2:0]                         state1_i
);
    // resampler_1ch state encoding
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CALC = 3'd3;

    logic calc_any;

    assign calc_any = (state0_i == ST_CALC) || (state1_i == ST_CALC);

    ack_exclusive: assert property (@(posedge clk) disable iff (rst) ack_i != 2'b11)
        else $error("ack_o high on both channels at once");

    ack_follows_req0: assert property (@(posedge clk) disable iff (rst)
        (req_i[0] && state0_i == ST_IDLE) |=> ack_i[0])
        else $error("channel 0 did not ack one cycle after its request");

    ack_follows_req1: assert property (@(posedge clk) disable iff (rst)
        (req_i[1] && state1_i == ST_IDLE) |=> ack_i[1])
        else $error("channel 1 did not ack one cycle after its request");

    operands_quiet: assert property (@(posedge clk) disable iff (rst)
        !calc_any |-> (mpcand_i == '0 && mplier_i == '0))
        else $error("multiplier operands nonzero with no channel calculating");

    // grant dropping mid-calculation is a usage error
    grant_held: assert property (@(posedge clk) disable iff (rst) calc_any |-> grant_i)
        else $error("grant low while a channel is calculating");

endmodule
